//--- project.f
rtl/gfx_pkg.sv
rtl/gfx_cmd_if.sv
rtl/gfx_wbs_port.sv
rtl/gfx_cmd_fifo.sv
rtl/gfx_regfile.sv
rtl/gfx_op_ctrl.sv
rtl/gfx_pixel_fmt.sv
rtl/gfx_top.sv
tb/gfx_chk.sv
tb/gfx_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the graphics front-end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps --top-module gfx_tb \
  -f project.f -Mdir obj_dir -o gfx_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/gfx_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit $status
fi
exit 0

//--- tb/gfx_tb.sv
// Directed testbench for the graphics register front end
// Single bus master, one access at a time, inputs change on the falling edge
// Expected register values kept in a local model indexed by word offset
`timescale 1ns/1ps
`default_nettype none

module gfx_tb import gfx_pkg::*; ();

  localparam int clk_period   = 8;
  // Roughly five times the cycles the tests need
  localparam int cycle_budget = 2500;
  localparam int ack_limit    = 100;
  localparam int poll_limit   = 64;
  localparam word_t op_bits   = 32'h0000_0700;

  logic       wbs_clk_i;
  logic       rst_i;
  logic       cs_i;
  logic       cyc_i;
  logic       stb_i;
  logic       we_i;
  logic [3:0] sel_i;
  reg_adr_t   adr_i;
  word_t      dat_i;
  logic       pipeline_ack_i;
  word_t      dat_o;
  logic       ack_o;
  logic       err_o;
  logic       rect_write_o;
  logic       line_write_o;
  logic       point_write_o;
  logic       clipping_enable_o;
  word_t      target_base_o;
  coord_t     target_size_x_o;
  coord_t     target_size_y_o;
  coord_t     clip0_x_o;
  coord_t     clip0_y_o;
  coord_t     clip1_x_o;
  coord_t     clip1_y_o;
  word_t      color0_o;
  bpp_t       bpp_o;
  bpp_t       cbpp_o;
  logic       rmw_o;

  // Applied register values by word offset
  word_t model [11];

  gfx_top dut0 (.*);

  bind gfx_top gfx_chk u_chk (
    .wbs_clk_i(wbs_clk_i), .rst_i(rst_i), .ack_o(ack_o), .err_o(err_o),
    .rect_write_o(rect_write_o), .line_write_o(line_write_o), .point_write_o(point_write_o)
  );

  initial begin
    wbs_clk_i = 1'b0;
    forever #(clk_period / 2) wbs_clk_i = ~wbs_clk_i;
  end

  function automatic int idx(input reg_adr_t adr);
    return int'(adr[7:2]);
  endfunction

  function automatic logic [2:0] strobes();
    return {point_write_o, line_write_o, rect_write_o};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_coord(input string name, input coord_t got, input coord_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s: got 0x%04h, expected 0x%04h", name, got, exp));
    end
  endtask

  task automatic check_bpp(input string name, input bpp_t got, input bpp_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s: got 0x%02h, expected 0x%02h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic bus_start(input logic we, input reg_adr_t adr, input word_t dat,
                           input logic [3:0] sel);
    @(negedge wbs_clk_i);
    cs_i  = 1'b1;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = we;
    sel_i = sel;
    adr_i = adr;
    dat_i = dat;
  endtask

  task automatic bus_release();
    cs_i  = 1'b0;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
    sel_i = 4'h0;
  endtask

  // Bus dropped at the falling edge where ack is seen
  task automatic wait_ack(input int limit, output bit got);
    got = 1'b0;
    for (int n = 0; n < limit && !got; n++) begin
      @(negedge wbs_clk_i);
      got = ack_o;
    end
    if (got) begin
      bus_release();
    end
  endtask

  task automatic wb_write(input reg_adr_t adr, input word_t dat);
    bit got;
    bus_start(1'b1, adr, dat, 4'hF);
    wait_ack(ack_limit, got);
    if (!got) begin
      abort_run($sformatf("No ack for a write to offset 0x%02h", adr));
    end
  endtask

  task automatic wb_read(input reg_adr_t adr, output word_t dat);
    bit got;
    bus_start(1'b0, adr, '0, 4'hF);
    wait_ack(ack_limit, got);
    if (!got) begin
      abort_run($sformatf("No ack for a read from offset 0x%02h", adr));
    end
    dat = dat_o;
  endtask

  // Partial select keeps err_o high while the access stays up
  task automatic wb_bad_sel(input reg_adr_t adr, input word_t dat);
    bus_start(1'b1, adr, dat, 4'b0011);
    repeat (4) begin
      @(negedge wbs_clk_i);
      check_bit("err_o", err_o, 1'b1);
      check_bit("ack_o", ack_o, 1'b0);
    end
    bus_release();
  endtask

  task automatic read_expect(input reg_adr_t adr, input word_t exp);
    word_t d;
    wb_read(adr, d);
    check_word($sformatf("dat_o at 0x%02h", adr), d, exp);
  endtask

  // Status polled until every queued write is popped
  task automatic wait_drained();
    word_t st;
    int polls;
    st = '1;
    polls = 0;
    while (st[31:16] != 16'h0) begin
      if (polls == poll_limit) begin
        abort_run("Command queue did not drain");
      end else begin
        wb_read(gfx_status, st);
        polls++;
      end
    end
  endtask

  task automatic pulse_pipeline_ack();
    @(negedge wbs_clk_i);
    pipeline_ack_i = 1'b1;
    @(negedge wbs_clk_i);
    pipeline_ack_i = 1'b0;
  endtask

  task automatic expect_strobe(input int op_bit, input string name);
    int n;
    n = 0;
    while (strobes() == 3'b000) begin
      if (n == ack_limit) begin
        abort_run($sformatf("%s never pulsed after the control write", name));
      end else begin
        @(negedge wbs_clk_i);
        n++;
      end
    end
    check_word("{point,line,rect}_write_o", word_t'(strobes()),
               word_t'(3'b001 << (op_bit - ctrl_rect)));
    @(negedge wbs_clk_i);
    check_word("{point,line,rect}_write_o", word_t'(strobes()), '0);
  endtask

  task automatic check_ports();
    word_t ctrl;
    ctrl = model[idx(gfx_control)];
    check_bit("clipping_enable_o", clipping_enable_o, ctrl[ctrl_clipping]);
    check_word("target_base_o", target_base_o, model[idx(gfx_target_base)]);
    check_coord("target_size_x_o", target_size_x_o, model[idx(gfx_target_size_x)][15:0]);
    check_coord("target_size_y_o", target_size_y_o, model[idx(gfx_target_size_y)][15:0]);
    check_coord("clip0_x_o", clip0_x_o, model[idx(gfx_clip0_x)][15:0]);
    check_coord("clip0_y_o", clip0_y_o, model[idx(gfx_clip0_y)][15:0]);
    check_coord("clip1_x_o", clip1_x_o, model[idx(gfx_clip1_x)][15:0]);
    check_coord("clip1_y_o", clip1_y_o, model[idx(gfx_clip1_y)][15:0]);
    check_word("color0_o", color0_o, model[idx(gfx_color0)]);
  endtask

  task automatic reset_test();
    // Strobes and bus responses quiet out of reset
    check_word("{point,line,rect}_write_o", word_t'(strobes()), '0);
    check_bit("ack_o", ack_o, 1'b0);
    check_bit("err_o", err_o, 1'b0);
    for (int i = 0; i < 11; i++) begin
      model[i] = '0;
    end
    model[idx(gfx_control)]       = 32'h1;
    model[idx(gfx_target_size_x)] = 32'd800;
    model[idx(gfx_target_size_y)] = 32'd600;
    model[idx(gfx_clip1_x)]       = 32'd800;
    model[idx(gfx_clip1_y)]       = 32'd600;
    model[idx(gfx_color_comp)]    = 32'h1555;
    for (int i = 0; i < 11; i++) begin
      read_expect(reg_adr_t'(i * 4), model[i]);
    end
    check_ports();
    // Pad 1 plus 5/5/5
    check_bpp("bpp_o", bpp_o, 6'd16);
    check_bpp("cbpp_o", cbpp_o, 6'd15);
    check_bit("rmw_o", rmw_o, 1'b0);
  endtask

  task automatic random_rw_test();
    word_t r;
    // Operation bits left clear so no operation starts
    r = $urandom();
    model[idx(gfx_control)] = r & ~op_bits;
    wb_write(gfx_control, model[idx(gfx_control)]);
    for (int i = 2; i < 11; i++) begin
      model[i] = $urandom();
      wb_write(reg_adr_t'(i * 4), model[i]);
    end
    wb_write(8'h30, $urandom());
    wait_drained();
    for (int i = 0; i < 11; i++) begin
      read_expect(reg_adr_t'(i * 4), model[i]);
    end
    check_ports();
    read_expect(8'h2C, '0);
    read_expect(8'h30, '0);
    read_expect(8'hFC, '0);
  endtask

  task automatic op_test(input int op_bit, input string name);
    word_t v0;
    word_t v1;
    word_t v2;
    v0 = $urandom();
    v1 = $urandom();
    v2 = $urandom();
    wb_write(gfx_control, model[idx(gfx_control)] | (word_t'(1) << op_bit));
    expect_strobe(op_bit, name);
    read_expect(gfx_status, 32'h0000_0001);
    // Queued behind the running operation
    wb_write(gfx_color0, v0);
    wb_write(gfx_target_base, v1);
    wb_write(gfx_color0, v2);
    read_expect(gfx_status, 32'h0003_0001);
    read_expect(gfx_color0, model[idx(gfx_color0)]);
    read_expect(gfx_target_base, model[idx(gfx_target_base)]);
    pulse_pipeline_ack();
    wait_drained();
    model[idx(gfx_color0)]      = v2;
    model[idx(gfx_target_base)] = v1;
    read_expect(gfx_status, '0);
    read_expect(gfx_control, model[idx(gfx_control)]);
    read_expect(gfx_color0, v2);
    read_expect(gfx_target_base, v1);
    check_ports();
  endtask

  task automatic backpressure_test();
    word_t vals [17];
    word_t seen [17];
    word_t r;
    word_t last;
    int n_seen;
    int n;
    bit got;
    // Low byte keeps consecutive values distinct
    for (int i = 0; i < 17; i++) begin
      r = $urandom();
      vals[i] = {r[31:8], 8'(i + 1)};
    end
    wb_write(gfx_control, model[idx(gfx_control)] | (word_t'(1) << ctrl_line));
    expect_strobe(ctrl_line, "line_write_o");
    for (int i = 0; i < 16; i++) begin
      wb_write(gfx_color0, vals[i]);
    end
    read_expect(gfx_status, 32'h0010_0001);
    bus_start(1'b1, gfx_color0, vals[16], 4'hF);
    wait_ack(50, got);
    if (got) begin
      abort_run("Write acked while the command queue was full");
    end
    n_seen = 0;
    n = 0;
    last = color0_o;
    fork
      begin
        pulse_pipeline_ack();
        wait_ack(ack_limit, got);
      end
      // Record every new color0 value as entries apply
      begin
        while (n_seen < 17 && n < 200) begin
          @(negedge wbs_clk_i);
          n++;
          if (color0_o != last) begin
            seen[n_seen] = color0_o;
            last = color0_o;
            n_seen++;
          end
        end
      end
    join
    if (!got) begin
      abort_run("Held write never acked after the queue started to drain");
    end
    if (n_seen != 17) begin
      abort_run($sformatf("Only %0d of 17 queued writes reached color0_o", n_seen));
    end
    for (int i = 0; i < 17; i++) begin
      check_word("color0_o", seen[i], vals[i]);
    end
    model[idx(gfx_color0)] = vals[16];
    wait_drained();
    read_expect(gfx_status, '0);
    read_expect(gfx_color0, vals[16]);
  endtask

  task automatic bad_sel_test();
    wb_bad_sel(gfx_color0, ~model[idx(gfx_color0)]);
    read_expect(gfx_status, '0);
    read_expect(gfx_color0, model[idx(gfx_color0)]);
    check_ports();
  endtask

  task automatic pixel_fmt_test();
    word_t r;
    bpp_t exp_bpp;
    bpp_t exp_cbpp;
    for (int i = 0; i < 8; i++) begin
      r = $urandom();
      wb_write(gfx_color_comp, r);
      wait_drained();
      // Two-stage format pipeline
      repeat (2) @(negedge wbs_clk_i);
      exp_cbpp = bpp_t'(r[11:8]) + bpp_t'(r[7:4]) + bpp_t'(r[3:0]);
      exp_bpp  = exp_cbpp + bpp_t'(r[15:12]);
      check_bpp("bpp_o", bpp_o, exp_bpp);
      check_bpp("cbpp_o", cbpp_o, exp_cbpp);
      check_bit("rmw_o", rmw_o, |exp_bpp[2:0]);
      read_expect(gfx_color_comp, r);
    end
  endtask

  initial begin
    #(cycle_budget * clk_period);
    abort_run("Watchdog expired before the tests finished");
  end

  initial begin
    void'($urandom(32'h31581e3d));
    rst_i          = 1'b1;
    cs_i           = 1'b0;
    cyc_i          = 1'b0;
    stb_i          = 1'b0;
    we_i           = 1'b0;
    sel_i          = 4'h0;
    adr_i          = '0;
    dat_i          = '0;
    pipeline_ack_i = 1'b0;
    repeat (10) @(negedge wbs_clk_i);
    rst_i = 1'b0;
    reset_test();
    random_rw_test();
    op_test(ctrl_rect, "rect_write_o");
    op_test(ctrl_line, "line_write_o");
    op_test(ctrl_point, "point_write_o");
    backpressure_test();
    bad_sel_test();
    pixel_fmt_test();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/gfx_chk.sv
// Protocol checks bound into gfx_top, inactive while rst_i is high
// Strobe rule covers back-to-back pulses only
`timescale 1ns/1ps
`default_nettype none

module gfx_chk (
  input logic wbs_clk_i,
  input logic rst_i,
  input logic ack_o,
  input logic err_o,
  input logic rect_write_o,
  input logic line_write_o,
  input logic point_write_o
);

  // Bus responses are exclusive
  ack_err_excl: assert property (@(posedge wbs_clk_i) disable iff (rst_i) !(ack_o && err_o))
    else $error("ack_o and err_o high in the same cycle");

  // One ack per access
  ack_single: assert property (@(posedge wbs_clk_i) disable iff (rst_i) ack_o |=> !ack_o)
    else $error("ack_o high in two cycles in a row");

  // Operation strobes last one cycle
  rect_pulse: assert property (@(posedge wbs_clk_i) disable iff (rst_i)
    rect_write_o |=> !rect_write_o)
    else $error("rect_write_o longer than one cycle");
  line_pulse: assert property (@(posedge wbs_clk_i) disable iff (rst_i)
    line_write_o |=> !line_write_o)
    else $error("line_write_o longer than one cycle");
  point_pulse: assert property (@(posedge wbs_clk_i) disable iff (rst_i)
    point_write_o |=> !point_write_o)
    else $error("point_write_o longer than one cycle");

endmodule

`default_nettype wire

//--- rtl/gfx_top.sv
// Register front end of the graphics accelerator, single clock wbs_clk_i
// Writes are queued and applied while the pipeline is idle
// fifo_adr_w up to 15 so the count fits the status word
`timescale 1ns/1ps
`default_nettype none

module gfx_top import gfx_pkg::*; #(
  parameter int gr_width   = 800,
  parameter int gr_height  = 600,
  parameter int fifo_adr_w = 4
) (
  input  logic       wbs_clk_i,
  input  logic       rst_i,
  input  logic       cs_i,
  input  logic       cyc_i,
  input  logic       stb_i,
  input  logic       we_i,
  input  logic [3:0] sel_i,
  input  reg_adr_t   adr_i,
  input  word_t      dat_i,
  input  logic       pipeline_ack_i,
  output word_t      dat_o,
  output logic       ack_o,
  output logic       err_o,
  output logic       rect_write_o,
  output logic       line_write_o,
  output logic       point_write_o,
  output logic       clipping_enable_o,
  output word_t      target_base_o,
  output coord_t     target_size_x_o,
  output coord_t     target_size_y_o,
  output coord_t     clip0_x_o,
  output coord_t     clip0_y_o,
  output coord_t     clip1_x_o,
  output coord_t     clip1_y_o,
  output word_t      color0_o,
  output bpp_t       bpp_o,
  output bpp_t       cbpp_o,
  output logic       rmw_o
);

  reg_adr_t    rd_adr;
  word_t       rd_dat;
  logic        op_start;
  logic        busy;
  logic [15:0] color_comp;

  gfx_cmd_if #(.fifo_adr_w(fifo_adr_w)) cmd ();

  gfx_wbs_port u_wbs (
    .wbs_clk_i, .rst_i, .cs_i, .cyc_i, .stb_i, .we_i, .sel_i, .adr_i, .dat_i,
    .rd_dat_i(rd_dat), .rd_adr_o(rd_adr), .dat_o, .ack_o, .err_o, .cmd(cmd.writer)
  );

  gfx_cmd_fifo #(.fifo_adr_w(fifo_adr_w)) u_fifo (
    .wbs_clk_i, .rst_i, .cmd(cmd.queue)
  );

  gfx_regfile #(.gr_width(gr_width), .gr_height(gr_height)) u_regs (
    .wbs_clk_i, .rst_i, .rd_adr_i(rd_adr), .busy_i(busy), .cmd(cmd.reader),
    .rd_dat_o(rd_dat), .op_start_o(op_start), .rect_write_o, .line_write_o,
    .point_write_o, .clipping_enable_o, .target_base_o, .target_size_x_o,
    .target_size_y_o, .clip0_x_o, .clip0_y_o, .clip1_x_o, .clip1_y_o, .color0_o,
    .color_comp_o(color_comp)
  );

  // Pop goes straight onto the queue side
  gfx_op_ctrl u_ctrl (
    .wbs_clk_i, .rst_i, .op_start_i(op_start), .pipeline_ack_i,
    .empty_i(cmd.empty), .pop_o(cmd.pop), .busy_o(busy)
  );

  gfx_pixel_fmt u_fmt (
    .wbs_clk_i, .color_comp_i(color_comp), .bpp_o, .cbpp_o, .rmw_o
  );

endmodule

`default_nettype wire

//--- rtl/gfx_pixel_fmt.sv
// Pixel format from the color-component register
// Outputs lag a register change by two cycles
`timescale 1ns/1ps
`default_nettype none

module gfx_pixel_fmt import gfx_pkg::*; (
  input  logic        wbs_clk_i,
  input  logic [15:0] color_comp_i,
  output bpp_t        bpp_o,
  output bpp_t        cbpp_o,
  output logic        rmw_o
);

  comp_t pad_q;
  comp_t red_q;
  comp_t green_q;
  comp_t blue_q;
  bpp_t  sum_w;

  // First stage, split fields
  always_ff @(posedge wbs_clk_i) begin
    pad_q   <= color_comp_i[15:12];
    red_q   <= color_comp_i[11:8];
    green_q <= color_comp_i[7:4];
    blue_q  <= color_comp_i[3:0];
  end

  assign sum_w = bpp_t'(pad_q) + bpp_t'(red_q) + bpp_t'(green_q) + bpp_t'(blue_q);

  // Second stage, sums
  always_ff @(posedge wbs_clk_i) begin
    bpp_o  <= sum_w;
    cbpp_o <= bpp_t'(red_q) + bpp_t'(green_q) + bpp_t'(blue_q);
    // Pixel not byte aligned
    rmw_o  <= |sum_w[2:0];
  end

endmodule

`default_nettype wire

//--- rtl/gfx_op_ctrl.sv
// Wait/busy sequencer gating queue pops
// At most one pop every two cycles, none while an operation runs
`timescale 1ns/1ps
`default_nettype none

module gfx_op_ctrl import gfx_pkg::*; (
  input  logic wbs_clk_i,
  input  logic rst_i,
  input  logic op_start_i,
  input  logic pipeline_ack_i,
  input  logic empty_i,
  output logic pop_o,
  output logic busy_o
);

  op_state_e state;
  // Entry popped last cycle, not yet applied
  logic      pop_q;

  // Hold off until a popped control write could show its strobe
  assign pop_o  = (state == wait_state) & ~op_start_i & ~empty_i & ~pop_q;
  assign busy_o = (state == busy_state);

  always_ff @(posedge wbs_clk_i) begin
    if (rst_i) begin
      state <= wait_state;
      pop_q <= 1'b0;
    end else begin
      pop_q <= pop_o;
      case (state)
        wait_state: begin
          if (op_start_i) begin
            state <= busy_state;
          end
        end
        // Pipeline done
        busy_state: begin
          if (pipeline_ack_i) begin
            state <= wait_state;
          end
        end
        default: state <= wait_state;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/gfx_regfile.sv
// Applied register set, written only from popped queue entries
// Operation bits become one-cycle strobes and read back as zero
// Full 32-bit words are kept, coordinate outputs use the low 16 bits
`timescale 1ns/1ps
`default_nettype none

module gfx_regfile import gfx_pkg::*; #(
  parameter int gr_width  = 800,
  parameter int gr_height = 600
) (
  input  logic        wbs_clk_i,
  input  logic        rst_i,
  input  reg_adr_t    rd_adr_i,
  input  logic        busy_i,
  gfx_cmd_if.reader   cmd,
  output word_t       rd_dat_o,
  output logic        op_start_o,
  output logic        rect_write_o,
  output logic        line_write_o,
  output logic        point_write_o,
  output logic        clipping_enable_o,
  output word_t       target_base_o,
  output coord_t      target_size_x_o,
  output coord_t      target_size_y_o,
  output coord_t      clip0_x_o,
  output coord_t      clip0_y_o,
  output coord_t      clip1_x_o,
  output coord_t      clip1_y_o,
  output word_t       color0_o,
  output logic [15:0] color_comp_o
);

  // Operation bits are masked off before storing
  localparam word_t op_mask = (word_t'(1) << ctrl_rect) | (word_t'(1) << ctrl_line) |
                              (word_t'(1) << ctrl_point);

  word_t control_q;
  word_t target_base_q;
  word_t size_x_q;
  word_t size_y_q;
  word_t clip0_x_q;
  word_t clip0_y_q;
  word_t clip1_x_q;
  word_t clip1_y_q;
  word_t color0_q;
  word_t color_comp_q;
  word_t status_w;
  logic  wr_ctrl;

  assign wr_ctrl = cmd.pop_valid && (cmd.pop_adr == gfx_control);

  // Apply entry at the end of its pop_valid cycle
  always_ff @(posedge wbs_clk_i) begin
    if (rst_i) begin
      control_q     <= word_t'(1) << ctrl_clipping;
      target_base_q <= '0;
      size_x_q      <= word_t'(gr_width);
      size_y_q      <= word_t'(gr_height);
      clip0_x_q     <= '0;
      clip0_y_q     <= '0;
      clip1_x_q     <= word_t'(gr_width);
      clip1_y_q     <= word_t'(gr_height);
      color0_q      <= '0;
      color_comp_q  <= word_t'(color_comp_reset);
    end else if (cmd.pop_valid) begin
      case (cmd.pop_adr)
        gfx_control:       control_q     <= cmd.pop_dat & ~op_mask;
        gfx_target_base:   target_base_q <= cmd.pop_dat;
        gfx_target_size_x: size_x_q      <= cmd.pop_dat;
        gfx_target_size_y: size_y_q      <= cmd.pop_dat;
        gfx_clip0_x:       clip0_x_q     <= cmd.pop_dat;
        gfx_clip0_y:       clip0_y_q     <= cmd.pop_dat;
        gfx_clip1_x:       clip1_x_q     <= cmd.pop_dat;
        gfx_clip1_y:       clip1_y_q     <= cmd.pop_dat;
        gfx_color0:        color0_q      <= cmd.pop_dat;
        gfx_color_comp:    color_comp_q  <= cmd.pop_dat;
        // Status and unmapped offsets ignored
        default: ;
      endcase
    end
  end

  // Strobes high for the cycle after the control write
  always_ff @(posedge wbs_clk_i) begin
    if (rst_i) begin
      rect_write_o  <= 1'b0;
      line_write_o  <= 1'b0;
      point_write_o <= 1'b0;
    end else begin
      rect_write_o  <= wr_ctrl & cmd.pop_dat[ctrl_rect];
      line_write_o  <= wr_ctrl & cmd.pop_dat[ctrl_line];
      point_write_o <= wr_ctrl & cmd.pop_dat[ctrl_point];
    end
  end

  // Sequencer leaves wait state on this
  assign op_start_o = rect_write_o | line_write_o | point_write_o;

  assign clipping_enable_o = control_q[ctrl_clipping];
  assign target_base_o     = target_base_q;
  assign target_size_x_o   = size_x_q[15:0];
  assign target_size_y_o   = size_y_q[15:0];
  assign clip0_x_o         = clip0_x_q[15:0];
  assign clip0_y_o         = clip0_y_q[15:0];
  assign clip1_x_o         = clip1_x_q[15:0];
  assign clip1_y_o         = clip1_y_q[15:0];
  assign color0_o          = color0_q;
  assign color_comp_o      = color_comp_q[15:0];

  // Busy flag plus queue fill level
  always_comb begin
    status_w            = '0;
    status_w[stat_busy] = busy_i;
    status_w[31:stat_count_lsb] = 16'(cmd.count);
  end

  // Read mux, pending queue entries not seen
  always_comb begin
    case (rd_adr_i)
      gfx_control:       rd_dat_o = control_q;
      gfx_status:        rd_dat_o = status_w;
      gfx_target_base:   rd_dat_o = target_base_q;
      gfx_target_size_x: rd_dat_o = size_x_q;
      gfx_target_size_y: rd_dat_o = size_y_q;
      gfx_clip0_x:       rd_dat_o = clip0_x_q;
      gfx_clip0_y:       rd_dat_o = clip0_y_q;
      gfx_clip1_x:       rd_dat_o = clip1_x_q;
      gfx_clip1_y:       rd_dat_o = clip1_y_q;
      gfx_color0:        rd_dat_o = color0_q;
      gfx_color_comp:    rd_dat_o = color_comp_q;
      default:           rd_dat_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/gfx_cmd_fifo.sv
// Synchronous command queue of address/data pairs, 2**fifo_adr_w entries
// Push when full and pop when empty are dropped
// One cycle read latency, pop_valid marks the output entry
`timescale 1ns/1ps
`default_nettype none

module gfx_cmd_fifo import gfx_pkg::*; #(
  parameter int fifo_adr_w = 4
) (
  input  logic      wbs_clk_i,
  input  logic      rst_i,
  gfx_cmd_if.queue  cmd
);

  reg_adr_t              adr_mem [2**fifo_adr_w];
  word_t                 dat_mem [2**fifo_adr_w];
  logic [fifo_adr_w-1:0] wr_ptr;
  logic [fifo_adr_w-1:0] rd_ptr;
  logic                  do_push;
  logic                  do_pop;

  assign do_push = cmd.push & ~cmd.full;
  assign do_pop  = cmd.pop & ~cmd.empty;

  // Count reaches 2**fifo_adr_w only when full
  assign cmd.full  = cmd.count[fifo_adr_w];
  assign cmd.empty = (cmd.count == '0);

  // Storage and output entry
  always_ff @(posedge wbs_clk_i) begin
    if (do_push) begin
      adr_mem[wr_ptr] <= cmd.push_adr;
      dat_mem[wr_ptr] <= cmd.push_dat;
    end
    if (do_pop) begin
      cmd.pop_adr <= adr_mem[rd_ptr];
      cmd.pop_dat <= dat_mem[rd_ptr];
    end
  end

  // Pointers wrap on their own width
  always_ff @(posedge wbs_clk_i) begin
    if (rst_i) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      cmd.count     <= '0;
      cmd.pop_valid <= 1'b0;
    end else begin
      cmd.pop_valid <= do_pop;
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   cmd.count <= cmd.count + 1'b1;
        2'b01:   cmd.count <= cmd.count - 1'b1;
        default: cmd.count <= cmd.count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/gfx_wbs_port.sv
// 32-bit Wishbone slave access decode, full-word accesses only
// Reads return applied values, queued writes are not visible
// Master must drop stb_i after ack_o
`timescale 1ns/1ps
`default_nettype none

module gfx_wbs_port import gfx_pkg::*; (
  input  logic       wbs_clk_i,
  input  logic       rst_i,
  input  logic       cs_i,
  input  logic       cyc_i,
  input  logic       stb_i,
  input  logic       we_i,
  input  logic [3:0] sel_i,
  input  reg_adr_t   adr_i,
  input  word_t      dat_i,
  input  word_t      rd_dat_i,
  output reg_adr_t   rd_adr_o,
  output word_t      dat_o,
  output logic       ack_o,
  output logic       err_o,
  gfx_cmd_if.writer  cmd
);

  logic acc;
  logic acc32;
  logic rd_take;
  logic wr_take;

  // Access to this block
  assign acc   = cs_i & cyc_i & stb_i;
  assign acc32 = (sel_i == 4'b1111);

  // Partial select flagged in the same cycle
  assign err_o = acc & ~acc32;

  // Word aligned address for read mux and queue
  assign rd_adr_o = {adr_i[7:2], 2'b00};

  // Ack cycle blocks a second take of the same access
  assign rd_take = acc & acc32 & ~we_i & ~ack_o;
  // Writes stall while the queue is full
  assign wr_take = acc & acc32 & we_i & ~ack_o & ~cmd.full;

  assign cmd.push     = wr_take;
  assign cmd.push_adr = rd_adr_o;
  assign cmd.push_dat = dat_i;

  always_ff @(posedge wbs_clk_i) begin
    if (rst_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= rd_take | wr_take;
    end
  end

  // Read data sampled with the take
  always_ff @(posedge wbs_clk_i) begin
    if (rd_take) begin
      dat_o <= rd_dat_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/gfx_cmd_if.sv
// Command queue connection, push side from the bus, pop side to the registers
// pop_valid follows pop by one cycle with the entry on pop_adr/pop_dat
`timescale 1ns/1ps
`default_nettype none

interface gfx_cmd_if import gfx_pkg::*; #(
  parameter int fifo_adr_w = 4
) ();

  // Push side
  logic     push;
  reg_adr_t push_adr;
  word_t    push_dat;
  logic     full;

  // Pop side
  logic                pop;
  logic                pop_valid;
  reg_adr_t            pop_adr;
  word_t               pop_dat;
  logic                empty;
  // Fill level, 0 up to 2**fifo_adr_w
  logic [fifo_adr_w:0] count;

  modport writer (output push, push_adr, push_dat, input full);
  modport queue (input push, push_adr, push_dat, pop,
                 output full, pop_valid, pop_adr, pop_dat, empty, count);
  modport reader (input pop_valid, pop_adr, pop_dat, empty, count);

endinterface

`default_nettype wire

//--- rtl/gfx_pkg.sv
// Register map and shared types of the graphics front end
// Offsets are byte addresses, bits 1:0 always zero
// Queue count must fit the 16-bit status field
`default_nettype none

package gfx_pkg;

  // Bus data and register word
  typedef logic [31:0] word_t;
  // Byte address inside the register block
  typedef logic [7:0] reg_adr_t;
  // Pixel coordinate or size
  typedef logic [15:0] coord_t;
  // Bits per pixel
  typedef logic [5:0] bpp_t;
  // One color component width
  typedef logic [3:0] comp_t;

  // Sequencer states
  typedef enum logic {
    wait_state = 1'b0,
    busy_state = 1'b1
  } op_state_e;

  // Register offsets
  localparam reg_adr_t gfx_control       = 8'h00;
  localparam reg_adr_t gfx_status        = 8'h04;
  localparam reg_adr_t gfx_target_base   = 8'h08;
  localparam reg_adr_t gfx_target_size_x = 8'h0C;
  localparam reg_adr_t gfx_target_size_y = 8'h10;
  localparam reg_adr_t gfx_clip0_x       = 8'h14;
  localparam reg_adr_t gfx_clip0_y       = 8'h18;
  localparam reg_adr_t gfx_clip1_x       = 8'h1C;
  localparam reg_adr_t gfx_clip1_y       = 8'h20;
  localparam reg_adr_t gfx_color0        = 8'h24;
  localparam reg_adr_t gfx_color_comp    = 8'h28;

  // Control bits, clipping resets to one
  localparam int ctrl_clipping = 0;
  // Operation bits, never stored
  localparam int ctrl_rect  = 8;
  localparam int ctrl_line  = 9;
  localparam int ctrl_point = 10;

  // Status layout
  localparam int stat_busy      = 0;
  localparam int stat_count_lsb = 16;

  // Pad 1, red/green/blue 5 bits each
  localparam logic [15:0] color_comp_reset = 16'h1555;

endpackage

`default_nettype wire
